/* Makefile */
TOOL      = verilator
TOP       = tb_exec_pipe
FILELIST  = build.f
FLAGS     = --binary --assert --timing -j 0 --top-module $(TOP)
RUN_FLAGS = +verilator+error+limit+100
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
verilog/exec_pkg.sv
verilog/stage_pipe.sv
verilog/hazard_check.sv
verilog/reg_file.sv
verilog/issue_stage.sv
verilog/alu_pipe.sv
verilog/exec_pipe_top.sv
sim/exec_pipe_properties.sv
sim/exec_pipe_checker.sv
sim/tb_exec_pipe.sv

/* sim/exec_pipe_checker.sv */
//########################################
// scoreboard for the execution pipeline.
// pairs each writeback with the oldest
// accepted instruction, runs it on a
// register model and checks the end state.
//########################################
`timescale 1ns/1ps

module exec_pipe_checker
(
  input  logic                clk,
  input  logic                reset,
  input  logic                flush,
  input  logic                in_valid,
  input  exec_pkg::instr_t    in_instr,
  input  logic                in_ready,
  input  logic                wb_valid,
  input  exec_pkg::reg_addr_t wb_dst,
  input  exec_pkg::data_t     wb_data,
  input  exec_pkg::data_t     final_regs [exec_pkg::REG_CNT], // expected end state.
  input  logic                run_done,       // stimulus over and drained.
  output int                  value_errors,
  output int                  other_errors,
  output int                  pending,        // accepted, not yet written back.
  output logic                check_done
);

  import exec_pkg::*;

  data_t  model [REG_CNT];                    // sequential reference state.
  data_t  wb_state [REG_CNT];                 // state built from DUT writebacks only.
  instr_t acc_q [$];                          // accepted, oldest first.
  int     acc_count;
  int     wb_count;
  int     flushed_count;

  // opcode rules of the instruction set.
  function automatic data_t reference_result(input instr_t ins, input data_t a,
                                             input data_t b);
    case (ins.op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_LI:   return {16'h0000, ins.imm};    // zero-extended.
      default: return '0;
    endcase
  endfunction

  task automatic check_writeback();
    instr_t ins;
    data_t  exp_val;
    wb_count++;
    wb_state[wb_dst] = wb_data;
    if (acc_q.size() == 0)
    begin
      other_errors++;
      $display("writeback to r%0d arrived with no instruction outstanding", wb_dst);
    end
    else
    begin
      ins     = acc_q.pop_front();            // in-order completion.
      exp_val = reference_result(ins, model[ins.src_a], model[ins.src_b]);
      model[ins.dst] = exp_val;
      if (wb_dst !== ins.dst)
      begin
        value_errors++;
        $display("** Error: wb_dst expected 0x%0h, actual 0x%0h", ins.dst, wb_dst);
      end
      if (wb_data !== exp_val)
      begin
        value_errors++;
        $display("** Error: wb_data expected 0x%08h, actual 0x%08h", exp_val, wb_data);
      end
    end
  endtask

  task automatic check_final();
    if (acc_q.size() != 0)
    begin
      other_errors++;
      $display("%0d accepted instructions never wrote back", acc_q.size());
    end
    if (acc_count != wb_count + flushed_count)
    begin
      other_errors++;
      $display("%0d accepted but %0d written back and %0d flushed",
               acc_count, wb_count, flushed_count);
    end
    for (int i = 0; i < REG_CNT; i++)
    begin
      if (model[i] !== final_regs[i])
      begin
        value_errors++;
        $display("** Error: model r%0d expected 0x%08h, actual 0x%08h",
                 i, final_regs[i], model[i]);
      end
      if (wb_state[i] !== final_regs[i])
      begin
        value_errors++;
        $display("** Error: wb_data r%0d expected 0x%08h, actual 0x%08h",
                 i, final_regs[i], wb_state[i]);
      end
    end
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < REG_CNT; i++)
      begin
        model[i]    = '0;
        wb_state[i] = '0;
      end
      acc_q.delete();
      acc_count     = 0;
      wb_count      = 0;
      flushed_count = 0;
      value_errors  = 0;
      other_errors  = 0;
      check_done    = 1'b0;
    end
    else
    begin
      if (wb_valid)
        check_writeback();                    // a flush-cycle writeback still counts.
      if (in_valid && in_ready)
      begin
        acc_q.push_back(in_instr);
        acc_count++;
      end
      if (flush)
      begin
        flushed_count += acc_q.size();        // everything left is squashed.
        acc_q.delete();
      end
      if (run_done && !check_done)
      begin
        check_final();
        check_done = 1'b1;
      end
    end
    pending = acc_q.size();
  end

endmodule

/* sim/exec_pipe_properties.sv */
//########################################
// concurrent assertions bound into the
// pipeline top. covers reset, flush and
// the input handshake.
//########################################
`timescale 1ns/1ps

module exec_pipe_properties
(
  input logic             clk,
  input logic             reset,
  input logic             flush,
  input logic             in_valid,
  input exec_pkg::instr_t in_instr,
  input logic             in_ready,
  input logic             wb_valid
);

  int fail_count = 0;                         // summed into the closing report.

  wb_idle_after_reset: assert property (@(posedge clk) reset |=> !wb_valid)
  else
  begin
    $error("wb_valid is high in the cycle after reset");
    fail_count++;
  end

  no_transfer_in_flush: assert property (@(posedge clk) flush |-> !(in_valid && in_ready))
  else
  begin
    $error("an instruction was accepted while flush was high");
    fail_count++;
  end

  // producer side, a waiting instruction may not change.
  instr_held_stable: assert property (@(posedge clk) disable iff (reset)
    (in_valid && !in_ready) |=> $stable(in_instr))
  else
  begin
    $error("in_instr changed while waiting for in_ready");
    fail_count++;
  end

endmodule

/* sim/exec_stim.txt */
# instr op dst src_a src_b imm(hex) flush ; op 0 add 1 sub 2 and 3 xor 4 li
# flush 1 opens a group squashed whole, 2 flushes after it ; final reg value(hex)
instr 4 1 0 0 1234 0
instr 4 2 0 0 00ff 0
instr 4 3 0 0 f0f0 0
instr 0 4 1 2 0000 0
instr 4 5 0 0 0001 0
instr 3 6 3 2 0000 0
instr 2 7 3 1 0000 0
instr 1 0 2 1 0000 0
instr 0 4 4 5 0000 0
instr 0 4 4 4 0000 0
instr 1 5 4 5 0000 0
instr 4 6 0 0 0010 0
instr 3 6 6 5 0000 0
instr 4 1 0 0 dead 1
instr 0 2 3 3 0000 0
instr 3 7 0 0 0000 2
instr 0 1 1 2 0000 0
instr 2 2 1 6 0000 0
instr 3 7 7 3 0000 0
instr 1 3 0 5 0000 0
final 0 ffffeecb
final 1 00001333
final 2 00000233
final 3 ffffc864
final 4 00002668
final 5 00002667
final 6 00002677
final 7 0000e0c0

/* sim/tb_exec_pipe.sv */
//########################################
// testbench for the execution pipeline.
// plays sim/exec_stim.txt into the DUT with
// random gaps and flushes, then reports.
//########################################
`timescale 1ns/1ps

module tb_exec_pipe;

  import exec_pkg::*;

  localparam int EXEC_DEPTH = 3;

  logic        clk;
  logic        reset;
  logic        flush;
  logic        in_valid;
  instr_t      in_instr;
  logic        in_ready;
  logic        wb_valid;
  reg_addr_t   wb_dst;
  data_t       wb_data;
  data_t       final_regs [REG_CNT];          // expected end state from the file.
  logic        run_done;
  logic        check_done;
  int          value_errors;
  int          other_errors;
  int          pending;
  int          file_errors;
  int          line_count;                    // data lines, sizes the watchdog.
  int          final_count;
  logic        loaded;
  logic [31:0] rng;                           // gap generator state.
  instr_t      stim_q [$];
  int          flag_q [$];                    // 1 opens a squashed group, 2 flushes.

  exec_pipe_top #(
    .EXEC_DEPTH (EXEC_DEPTH)
  ) exec_pipe_top_i (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_ready (in_ready),
    .wb_valid (wb_valid),
    .wb_dst   (wb_dst),
    .wb_data  (wb_data)
  );

  exec_pipe_checker checker_i (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .in_ready     (in_ready),
    .wb_valid     (wb_valid),
    .wb_dst       (wb_dst),
    .wb_data      (wb_data),
    .final_regs   (final_regs),
    .run_done     (run_done),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .pending      (pending),
    .check_done   (check_done)
  );

  bind exec_pipe_top exec_pipe_properties props_i (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_ready (in_ready),
    .wb_valid (wb_valid)
  );

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_stimulus();
    int          fd;
    string       line;
    logic [39:0] tag;
    int          col [6];
    instr_t      ins;
    fd = $fopen("sim/exec_stim.txt", "r");
    if (fd == 0)
    begin
      file_errors++;
      $display("cannot open sim/exec_stim.txt for reading");
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if ($sscanf(line, "%s", tag) < 1 || line.getc(0) == "#")
          continue;                           // blank or comment line.
        line_count++;
        if (tag == "instr" && $sscanf(line, "%s %d %d %d %d %h %d", tag, col[0],
            col[1], col[2], col[3], col[4], col[5]) == 7)
        begin
          ins.op    = op_e'(col[0][2:0]);
          ins.dst   = col[1][2:0];
          ins.src_a = col[2][2:0];
          ins.src_b = col[3][2:0];
          ins.imm   = col[4][15:0];
          stim_q.push_back(ins);
          flag_q.push_back(col[5]);
        end
        else if (tag == "final" && $sscanf(line, "%s %d %h", tag, col[0], col[4]) == 3)
        begin
          final_regs[col[0][2:0]] = col[4];
          final_count++;
        end
        else
        begin
          file_errors++;
          $display("stimulus line could not be read: %s", line);
        end
      end
      $fclose(fd);
      if (final_count != REG_CNT)
      begin
        file_errors++;
        $display("stimulus file gives %0d final registers instead of 8", final_count);
      end
    end
  endtask

  // offers the instruction until it is taken, flush high in the first cycle
  // when asked, and returns on a falling edge.
  task automatic send_instr(input instr_t ins, input logic with_flush);
    logic taken;
    taken    = 1'b0;
    flush    = with_flush;
    in_valid = 1'b1;
    in_instr = ins;
    while (!taken)
    begin
      @(posedge clk);
      taken = in_ready;                       // value before this edge's updates.
      @(negedge clk);
      flush = 1'b0;                           // a flush lasts one cycle.
    end
    in_valid = 1'b0;
  endtask

  task automatic flush_pipe();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic wait_drained();
    while (pending != 0)
      @(negedge clk);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    wait (loaded);
    // worst case per line is a 3 cycle gap plus a full interlock wait.
    #(line_count * (EXEC_DEPTH + 5) * 10 + 1000);
    $display("watchdog expired, the run did not finish in time");
    $display("Something failed");
    $finish;
  end

  initial
  begin
    logic in_group;
    logic flush_next;
    reset      = 1'b1;
    flush      = 1'b0;
    in_valid   = 1'b0;
    in_instr   = '0;
    run_done   = 1'b0;
    in_group   = 1'b0;
    flush_next = 1'b0;
    rng        = 32'd94;
    file_errors = 0;
    line_count  = 0;
    final_count = 0;
    for (int i = 0; i < REG_CNT; i++)
      final_regs[i] = '0;
    load_stimulus();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (file_errors == 0)
    begin
      for (int i = 0; i < stim_q.size(); i++)
      begin
        if (flag_q[i] == 1)
        begin
          wait_drained();                     // group then dies wholly in flight.
          in_group = 1'b1;
        end
        else if (!in_group && !flush_next)
        begin
          rng = next_random(rng);
          repeat (rng[1:0]) @(negedge clk);
        end
        send_instr(stim_q[i], flush_next);    // next one waits out the flush cycle.
        flush_next = (flag_q[i] == 2);
        if (flush_next)
          in_group = 1'b0;
      end
      if (flush_next)
        flush_pipe();
      wait_drained();
      run_done = 1'b1;
      wait (check_done);
    end
    $display("closing report: %0d value errors, %0d other errors, %0d assertion failures",
             value_errors, other_errors + file_errors, exec_pipe_top_i.props_i.fail_count);
    if (value_errors + other_errors + file_errors + exec_pipe_top_i.props_i.fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* verilog/alu_pipe.sv */
//######################################
// one-cycle ALU followed by the delay chain.
// the oldest stage of stage_bus is the
// writeback to the register file.
//######################################
`timescale 1ns/1ps

module alu_pipe
#(
  parameter int EXEC_DEPTH = 3                // delay registers after the ALU.
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic             flush,             // squashes all stages.
  input  logic             iss_valid,
  input  exec_pkg::instr_t iss_instr,
  input  exec_pkg::data_t  iss_a,
  input  exec_pkg::data_t  iss_b,
  output exec_pkg::wb_t    stage_bus [EXEC_DEPTH]
);

  import exec_pkg::*;

  data_t result;                              // ALU output.
  wb_t   alu_wb;                              // record entering stage 0.

  always_comb
  begin
    case (iss_instr.op)
      OP_ADD:  result = iss_a + iss_b;
      OP_SUB:  result = iss_a - iss_b;
      OP_AND:  result = iss_a & iss_b;
      OP_XOR:  result = iss_a ^ iss_b;
      OP_LI:   result = DATA_W'(iss_instr.imm); // upper bits zero.
      default: result = '0;                   // unused codes write zero.
    endcase
  end

  always_comb
  begin
    alu_wb.valid  = iss_valid;
    alu_wb.dst    = iss_instr.dst;
    alu_wb.result = result;
  end

  stage_pipe #(
    .DEPTH (EXEC_DEPTH)
  ) delay_i (
    .clk    (clk),
    .reset  (reset),
    .squash (flush),
    .d      (alu_wb),
    .q      (stage_bus)
  );

endmodule

/* verilog/exec_pipe_top.sv */
//######################################
// execution pipeline top. instruction in on
// valid/ready, result out on the wb ports,
// EXEC_DEPTH + 1 cycles from issue to write.
//######################################
`timescale 1ns/1ps

module exec_pipe_top
#(
  parameter int EXEC_DEPTH = 3                // delay registers after the ALU.
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                flush,
  input  logic                in_valid,
  input  exec_pkg::instr_t    in_instr,
  output logic                in_ready,
  output logic                wb_valid,
  output exec_pkg::reg_addr_t wb_dst,
  output exec_pkg::data_t     wb_data
);

  import exec_pkg::*;

  instr_t held_instr;                         // waiting instruction.
  logic   held_valid;
  logic   stall;
  logic   iss_valid;
  instr_t iss_instr;
  data_t  iss_a;
  data_t  iss_b;
  data_t  rd_a_data;
  data_t  rd_b_data;
  wb_t    stage_bus [EXEC_DEPTH];             // all in-flight results.
  wb_t    wb;                                 // oldest stage.

  issue_stage issue_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .stall      (stall),
    .rd_a_data  (rd_a_data),
    .rd_b_data  (rd_b_data),
    .in_ready   (in_ready),
    .held_instr (held_instr),
    .held_valid (held_valid),
    .iss_valid  (iss_valid),
    .iss_instr  (iss_instr),
    .iss_a      (iss_a),
    .iss_b      (iss_b)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .reset     (reset),
    .rd_a      (held_instr.src_a),
    .rd_b      (held_instr.src_b),
    .wr        (wb),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data)
  );

  alu_pipe #(
    .EXEC_DEPTH (EXEC_DEPTH)
  ) alu_pipe_i (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .iss_valid (iss_valid),
    .iss_instr (iss_instr),
    .iss_a     (iss_a),
    .iss_b     (iss_b),
    .stage_bus (stage_bus)
  );

  hazard_check #(
    .DEPTH (EXEC_DEPTH)
  ) hazard_i (
    .instr       (held_instr),
    .instr_valid (held_valid),
    .stage_bus   (stage_bus),
    .stall       (stall)
  );

  assign wb       = stage_bus[EXEC_DEPTH-1];  // written even during a flush.
  assign wb_valid = wb.valid;
  assign wb_dst   = wb.dst;
  assign wb_data  = wb.result;

endmodule

/* verilog/exec_pkg.sv */
//######################################
// shared widths, opcodes and records of the
// execution pipeline. every RTL module that
// names one of these types imports it here.
//######################################
package exec_pkg;

  localparam int DATA_W  = 32;                // width of a data word.
  localparam int REG_CNT = 8;                 // registers in the register file.

  typedef logic [$clog2(REG_CNT)-1:0] reg_addr_t; // register index.
  typedef logic [DATA_W-1:0]          data_t;     // one data word.

  // opcodes, 3 bits wide; codes 5 to 7 are unused.
  typedef enum logic [2:0]
  {
    OP_ADD = 3'd0,                            // src_a + src_b.
    OP_SUB = 3'd1,                            // src_a - src_b.
    OP_AND = 3'd2,                            // src_a & src_b.
    OP_XOR = 3'd3,                            // src_a ^ src_b.
    OP_LI  = 3'd4                             // zero-extended imm, no sources.
  } op_e;

  // instruction word, 28 bits.
  typedef struct packed
  {
    op_e         op;                          // operation.
    reg_addr_t   dst;                         // destination register.
    reg_addr_t   src_a;                       // first source.
    reg_addr_t   src_b;                       // second source.
    logic [15:0] imm;                         // immediate for OP_LI.
  } instr_t;

  // writeback record carried down the delay chain, 36 bits.
  typedef struct packed
  {
    logic      valid;                         // record holds a live result.
    reg_addr_t dst;                           // register to write.
    data_t     result;                        // value to write.
  } wb_t;

endpackage

/* verilog/hazard_check.sv */
//######################################
// read-after-write interlock. compares the
// held instruction's sources with the dst
// of every valid in-flight stage.
//######################################
`timescale 1ns/1ps

module hazard_check
#(
  parameter int DEPTH = 3                     // stages to compare against.
)
(
  input  exec_pkg::instr_t instr,             // instruction waiting to issue.
  input  logic             instr_valid,       // issue register is occupied.
  input  exec_pkg::wb_t    stage_bus [DEPTH], // in-flight writebacks.
  output logic             stall              // hold the instruction this cycle.
);

  import exec_pkg::*;

  logic uses_src;                             // instruction reads registers.
  logic hit_a;                                // src_a pending in some stage.
  logic hit_b;                                // src_b pending in some stage.

  always_comb
  begin
    hit_a = 1'b0;
    hit_b = 1'b0;
    for (int i = 0; i < DEPTH; i++)
    begin
      // the last stage counts too, its write lands at the end of this cycle.
      if (stage_bus[i].valid && (stage_bus[i].dst == instr.src_a))
        hit_a = 1'b1;
      if (stage_bus[i].valid && (stage_bus[i].dst == instr.src_b))
        hit_b = 1'b1;
    end
  end

  assign uses_src = (instr.op != OP_LI);      // li never waits.
  assign stall    = instr_valid && uses_src && (hit_a || hit_b);

endmodule

/* verilog/issue_stage.sv */
//######################################
// issue register behind a valid/ready input.
// holds one instruction until the interlock
// clears, then issues it with its operands.
//######################################
`timescale 1ns/1ps

module issue_stage
(
  input  logic             clk,
  input  logic             reset,
  input  logic             flush,             // empties the issue register.
  input  logic             in_valid,
  input  exec_pkg::instr_t in_instr,
  input  logic             stall,             // from the hazard check.
  input  exec_pkg::data_t  rd_a_data,         // register file read of src_a.
  input  exec_pkg::data_t  rd_b_data,         // register file read of src_b.
  output logic             in_ready,
  output exec_pkg::instr_t held_instr,        // drives read indices and hazard check.
  output logic             held_valid,
  output logic             iss_valid,         // instruction leaves this cycle.
  output exec_pkg::instr_t iss_instr,
  output exec_pkg::data_t  iss_a,
  output exec_pkg::data_t  iss_b
);

  import exec_pkg::*;

  instr_t held_q;                             // the waiting instruction.
  logic   held_v;                             // held_q is occupied.
  logic   accept;                             // transfer on the input this cycle.

  assign iss_valid = held_v && !stall;
  // take a new one when empty or when the current one goes out now.
  assign in_ready  = (!held_v || iss_valid) && !flush;
  assign accept    = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (reset || flush)
      held_v <= 1'b0;
    else if (accept)
      held_v <= 1'b1;                         // refill, possibly while issuing.
    else if (iss_valid)
      held_v <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      held_q <= in_instr;                     // payload, no reset.
  end

  assign held_instr = held_q;
  assign held_valid = held_v;

  // operands come straight from the register file in the issue cycle.
  assign iss_instr = held_q;
  assign iss_a     = rd_a_data;
  assign iss_b     = rd_b_data;

endmodule

/* verilog/reg_file.sv */
//######################################
// 8 x 32 register file, two asynchronous
// read ports and one write port fed by
// the writeback record.
//######################################
`timescale 1ns/1ps

module reg_file
(
  input  logic                clk,
  input  logic                reset,
  input  exec_pkg::reg_addr_t rd_a,           // read index, port a.
  input  exec_pkg::reg_addr_t rd_b,           // read index, port b.
  input  exec_pkg::wb_t       wr,             // write request.
  output exec_pkg::data_t     rd_a_data,      // read data, port a.
  output exec_pkg::data_t     rd_b_data       // read data, port b.
);

  import exec_pkg::*;

  data_t regs [REG_CNT];                      // register storage.

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < REG_CNT; i++)
      begin
        regs[i] <= '0;                        // architectural state starts at zero.
      end
    end
    else if (wr.valid)
      regs[wr.dst] <= wr.result;
  end

  assign rd_a_data = regs[rd_a];              // no bypass of the write in progress.
  assign rd_b_data = regs[rd_b];

endmodule

/* verilog/stage_pipe.sv */
//######################################
// shift chain of writeback records. every
// stage is visible on q for hazard checks,
// the last one is the writeback itself.
//######################################
`timescale 1ns/1ps

module stage_pipe
#(
  parameter int DEPTH = 3                     // number of delay registers.
)
(
  input  logic           clk,
  input  logic           reset,
  input  logic           squash,              // drops every record in flight.
  input  exec_pkg::wb_t  d,                   // record entering stage 0.
  output exec_pkg::wb_t  q [DEPTH]            // all stages, q[DEPTH-1] is the oldest.
);

  always_ff @(posedge clk)
  begin
    q[0] <= d;                                // payload moves every cycle.
    for (int i = 1; i < DEPTH; i++)
    begin
      q[i] <= q[i-1];
    end
    // only the valid bits need clearing, later assignment wins.
    if (reset || squash)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        q[i].valid <= 1'b0;
      end
    end
  end

endmodule
